/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	typedef logic [15:0] instr_t;    // one instruction word
	typedef logic [2:0]  reg_idx_t;  // r0..r7
	typedef logic [7:0]  reg_mask_t; // active low, one bit per register
	typedef logic [11:0] imm_hi_t;   // upper twelve bits of pout

	localparam instr_t NOP_WORD = 16'h0000;

	// upper nibble classes
	localparam logic [3:0] CLS_IMM    = 4'h1;
	localparam logic [3:0] CLS_ALU_RR = 4'h2;
	localparam logic [3:0] CLS_ALU_RI = 4'h3;
	localparam logic [3:0] CLS_BRANCH = 4'h4;
	localparam logic [3:0] CLS_MEM    = 4'h5;
	localparam logic [2:0] CLS3_ALU_RRR = 3'b100; // top three bits only

	localparam reg_idx_t PC_IDX = 3'd7; // program counter

	// field positions, low bit of each field
	localparam int unsigned F_CLS_LO  = 12; // class nibble
	localparam int unsigned F_OP_LO   = 8;  // alu op, 4 bits
	localparam int unsigned F_OP_HI   = 3;  // alu op bit 4, rr form
	localparam int unsigned F_IMM_LO  = 0;  // low nibble constant
	localparam int unsigned F_DST_LO  = 4;  // dest / store source
	localparam int unsigned F_SRC_LO  = 0;  // source / memory index
	localparam int unsigned F_NOSTORE = 7;
	localparam int unsigned F_MEM_ST  = 8;  // 1 = store
	localparam int unsigned F_NOINC   = 9;  // 0 = post increment
	localparam int unsigned F_NODEC   = 10; // 0 = post decrement
	localparam int unsigned F_COND_LO = 8;
	localparam int unsigned F_BR_IND  = 11;
	localparam int unsigned F_OP3_LO  = 9;  // three reg form op
	localparam int unsigned F_DST3_LO = 6;
	localparam int unsigned F_SRC2_LO = 3;

	typedef enum logic [2:0] {
		BZ, BNZ, BS, BNS, BC, BNC, BA, BL
	} br_cond_t;

	// active low one-hot select of a single register
	function automatic reg_mask_t sel_mask(input reg_idx_t idx);
		sel_mask = ~(8'h01 << idx);
	endfunction

endpackage

`default_nettype wire

/* design/ctl_pkg.sv */
`default_nettype none

package ctl_pkg;
	import isa_pkg::*;

	typedef struct packed {
		logic [4:0] alu_op;
		logic [3:0] pout_lo;           // low nibble of pout
		reg_mask_t  ld_alu_b;          // load from alu result
		reg_mask_t  ld_mem_b;          // load from memory bus
		reg_mask_t  ld_pout_b;         // load from pout
		reg_mask_t  inc_b;
		reg_mask_t  dec_b;
		reg_idx_t   alu_a_sel;
		reg_idx_t   alu_b_sel;
		reg_idx_t   m_sel;             // register onto memory bus
		reg_idx_t   maddr_sel;         // register onto address bus
		logic       m_en_b;
		logic       alu_b_from_pout_b;
		logic       mem_oe_b;
		logic       mem_wr_b;
	} ctl_word_t;

	localparam ctl_word_t CTL_IDLE = '{
		alu_op:            '0,
		pout_lo:           '0,
		ld_alu_b:          '1,
		ld_mem_b:          '1,
		ld_pout_b:         '1,
		inc_b:             '1,
		dec_b:             '1,
		alu_a_sel:         '0,
		alu_b_sel:         '0,
		m_sel:             '0,
		maddr_sel:         '0,
		m_en_b:            1'b1,
		alu_b_from_pout_b: 1'b1,
		mem_oe_b:          1'b1,
		mem_wr_b:          1'b1
	};

	typedef enum logic [1:0] {
		SEQ_RUN,   // normal fetch
		SEQ_STALL, // load data cycle
		SEQ_FLUSH  // branch delay slot
	} seq_state_t;

endpackage

`default_nettype wire

/* design/pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pipe_if
	import isa_pkg::*, ctl_pkg::*;
();
	instr_t     stage0;     // word being decoded
	instr_t     stage1;     // word one cycle older
	imm_hi_t    imm_hi;     // current prefix
	imm_hi_t    imm_next;   // prefix for next cycle
	logic       take_fetch; // latch memoryIn into stage 0
	logic       stall_req;
	logic       flush_req;
	seq_state_t seq_state;

	modport fetch (output stage0, stage1, imm_hi, input take_fetch, imm_next);
	modport dec   (input stage0, imm_hi, seq_state,
	               output take_fetch, imm_next, stall_req, flush_req);
	modport seq   (input stall_req, flush_req, output seq_state);
	modport done  (input stage1, seq_state);

endinterface

`default_nettype wire

/* design/fetch_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pipe
	import isa_pkg::*;
(
	input  logic   CLK,
	input  logic   RSTb,
	input  instr_t memoryIn, // word read at the fetch address
	pipe_if.fetch  pipe
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pipe.stage0 <= NOP_WORD;
			pipe.stage1 <= NOP_WORD;
			pipe.imm_hi <= '0;
		end else begin
			if (pipe.take_fetch) begin
				pipe.stage0 <= memoryIn; // new word from memory
			end else begin
				pipe.stage0 <= NOP_WORD; // bubble
			end
			pipe.stage1 <= pipe.stage0;   // shift every cycle
			pipe.imm_hi <= pipe.imm_next; // prefix lives one instruction
		end
	end

endmodule

`default_nettype wire

/* design/issue_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_sequencer
	import ctl_pkg::*;
(
	input  logic CLK,
	input  logic RSTb,
	pipe_if.seq  pipe
);

	seq_state_t state_q;
	seq_state_t state_d;

	always_comb begin
		state_d = SEQ_RUN; // stall and flush last one cycle
		case (state_q)
			SEQ_RUN: begin
				if (pipe.stall_req) begin
					state_d = SEQ_STALL; // load needs the memory bus
				end else if (pipe.flush_req) begin
					state_d = SEQ_FLUSH; // read at the new pc
				end
			end
			SEQ_STALL: state_d = SEQ_RUN;
			SEQ_FLUSH: state_d = SEQ_RUN;
			default:   state_d = SEQ_RUN;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q <= SEQ_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	assign pipe.seq_state = state_q;

endmodule

`default_nettype wire

/* design/stage0_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module stage0_decoder
	import isa_pkg::*, ctl_pkg::*;
(
	input  logic      C,       // carry
	input  logic      Z,       // zero
	input  logic      S,       // sign
	pipe_if.dec       pipe,
	output ctl_word_t pre_ctl
);

	instr_t     p0;
	logic [3:0] cls;
	reg_idx_t   dst;
	reg_idx_t   src;
	br_cond_t   cond;

	assign p0   = pipe.stage0;
	assign cls  = p0[F_CLS_LO +: 4];
	assign dst  = p0[F_DST_LO +: 3];
	assign src  = p0[F_SRC_LO +: 3]; // also the memory index
	assign cond = br_cond_t'(p0[F_COND_LO +: 3]);

	function automatic logic cond_met(input br_cond_t bc, input logic c, z, s);
		cond_met = 1'b0;
		case (bc)
			BZ:  cond_met = z;
			BNZ: cond_met = !z;
			BS:  cond_met = s;
			BNS: cond_met = !s;
			BC:  cond_met = c;
			BNC: cond_met = !c;
			BA:  cond_met = 1'b1;
			BL:  cond_met = 1'b0; // not supported, falls through as nop
		endcase
	endfunction

	always_comb begin
		pre_ctl         = CTL_IDLE;
		pipe.take_fetch = 1'b0;
		pipe.imm_next   = '0; // prefix cleared by any issued word
		pipe.stall_req  = 1'b0;
		pipe.flush_req  = 1'b0;

		// fetch defaults
		if (pipe.seq_state != SEQ_STALL) begin
			pre_ctl.maddr_sel = PC_IDX; // read at pc
			pre_ctl.mem_oe_b  = 1'b0;
		end
		if (pipe.seq_state == SEQ_RUN) begin
			pre_ctl.inc_b[PC_IDX] = 1'b0; // step pc past the fetched word
			pipe.take_fetch       = 1'b1;
		end else begin
			pipe.imm_next = pipe.imm_hi; // bubbles keep the prefix
		end

		if (p0[15:13] == CLS3_ALU_RRR) begin
			pre_ctl.alu_op    = {1'b0, p0[F_OP3_LO +: 4]};
			pre_ctl.alu_a_sel = p0[F_SRC2_LO +: 3];
			pre_ctl.alu_b_sel = src;
			pre_ctl.ld_alu_b  = sel_mask(p0[F_DST3_LO +: 3]); // always stores
		end else begin
			case (cls)
				CLS_IMM: begin
					pipe.imm_next = imm_hi_t'(p0); // low twelve bits
				end
				CLS_ALU_RR: begin
					pre_ctl.alu_op    = {p0[F_OP_HI], p0[F_OP_LO +: 4]};
					pre_ctl.alu_a_sel = dst;
					pre_ctl.alu_b_sel = src;
					if (!p0[F_NOSTORE]) begin
						pre_ctl.ld_alu_b = sel_mask(dst);
					end
				end
				CLS_ALU_RI: begin
					pre_ctl.alu_op            = {1'b0, p0[F_OP_LO +: 4]};
					pre_ctl.pout_lo           = p0[F_IMM_LO +: 4];
					pre_ctl.alu_a_sel         = dst;
					pre_ctl.alu_b_from_pout_b = 1'b0; // b operand is pout
					if (!p0[F_NOSTORE]) begin
						pre_ctl.ld_alu_b = sel_mask(dst);
					end
				end
				CLS_BRANCH: begin
					// direct form only, indirect acts as nop
					if (!p0[F_BR_IND] && cond_met(cond, C, Z, S)) begin
						pre_ctl.pout_lo       = p0[F_IMM_LO +: 4];
						pre_ctl.ld_pout_b     = sel_mask(PC_IDX); // pc <= pout
						pre_ctl.inc_b[PC_IDX] = 1'b1;
						pipe.take_fetch       = 1'b0; // drop the word behind
						pipe.flush_req        = 1'b1;
					end
				end
				CLS_MEM: begin
					if (!p0[F_MEM_ST]) begin
						pre_ctl.maddr_sel = src; // index
						pipe.stall_req    = 1'b1; // data arrives from stage 1
					end else begin
						pre_ctl.maddr_sel  = src;
						pre_ctl.m_en_b     = 1'b0;
						pre_ctl.m_sel      = dst; // store source
						pre_ctl.mem_oe_b   = 1'b1;
						pre_ctl.mem_wr_b   = 1'b0;
						pre_ctl.inc_b[src] = p0[F_NOINC];
						pre_ctl.dec_b[src] = p0[F_NODEC];
					end
					// fetched word discarded, rewind pc
					pre_ctl.dec_b[PC_IDX] = 1'b0;
					pre_ctl.inc_b[PC_IDX] = 1'b1;
					pipe.take_fetch       = 1'b0;
				end
				default: ; // nop and unsupported classes
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/load_completer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_completer
	import isa_pkg::*, ctl_pkg::*;
(
	pipe_if.done      pipe,
	input  ctl_word_t pre_ctl, // stage 0 decode
	output ctl_word_t ctl      // final control word
);

	instr_t   p1;
	reg_idx_t idx;
	reg_idx_t dst;
	logic     finish_load;

	assign p1  = pipe.stage1;
	assign idx = p1[F_SRC_LO +: 3];
	assign dst = p1[F_DST_LO +: 3];

	// load sits in stage 1 while the sequencer holds the stall
	assign finish_load = (p1[F_CLS_LO +: 4] == CLS_MEM) && !p1[F_MEM_ST]
		&& (pipe.seq_state == SEQ_STALL);

	always_comb begin
		ctl = pre_ctl;
		if (finish_load) begin
			ctl.maddr_sel  = idx;
			ctl.mem_oe_b   = 1'b0; // read the data word
			ctl.mem_wr_b   = 1'b1;
			ctl.ld_mem_b   = sel_mask(dst);
			ctl.inc_b[idx] = p1[F_NOINC]; // post increment
			ctl.dec_b[idx] = p1[F_NODEC]; // post decrement
		end
	end

endmodule

`default_nettype wire

/* design/pipeline16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline16_top
	import isa_pkg::*, ctl_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTb,
	input  instr_t      memoryIn,
	input  logic        C,                // alu flags
	input  logic        Z,
	input  logic        S,
	output logic [4:0]  aluOp,
	output logic [15:0] pout,             // pipeline constant
	output reg_mask_t   LD_reg_ALUb,
	output reg_mask_t   LD_reg_Mb,
	output reg_mask_t   LD_reg_Pb,
	output reg_idx_t    ALU_A_SEL,
	output reg_idx_t    ALU_B_SEL,
	output logic        M_ENb,
	output reg_idx_t    M_SEL,
	output reg_idx_t    MADDR_SEL,
	output reg_mask_t   INCb,
	output reg_mask_t   DECb,
	output logic        ALU_B_from_inP_b, // 0 = alu b from pout
	output logic        mem_OEb,
	output logic        mem_WRb
);

	ctl_word_t pre_ctl; // decoder to completer
	ctl_word_t ctl;

	pipe_if pipe ();

	fetch_pipe u_fetch (.CLK(CLK), .RSTb(RSTb), .memoryIn(memoryIn), .pipe(pipe.fetch));

	issue_sequencer u_seq (.CLK(CLK), .RSTb(RSTb), .pipe(pipe.seq));

	stage0_decoder u_dec (.C(C), .Z(Z), .S(S), .pipe(pipe.dec), .pre_ctl(pre_ctl));

	load_completer u_done (.pipe(pipe.done), .pre_ctl(pre_ctl), .ctl(ctl));

	assign pout             = {pipe.imm_hi, ctl.pout_lo}; // prefix on top
	assign aluOp            = ctl.alu_op;
	assign LD_reg_ALUb      = ctl.ld_alu_b;
	assign LD_reg_Mb        = ctl.ld_mem_b;
	assign LD_reg_Pb        = ctl.ld_pout_b;
	assign ALU_A_SEL        = ctl.alu_a_sel;
	assign ALU_B_SEL        = ctl.alu_b_sel;
	assign M_ENb            = ctl.m_en_b;
	assign M_SEL            = ctl.m_sel;
	assign MADDR_SEL        = ctl.maddr_sel;
	assign INCb             = ctl.inc_b;
	assign DECb             = ctl.dec_b;
	assign ALU_B_from_inP_b = ctl.alu_b_from_pout_b;
	assign mem_OEb          = ctl.mem_oe_b;
	assign mem_WRb          = ctl.mem_wr_b;

endmodule

`default_nettype wire

/* test/pipeline16_props.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline16_props
	import isa_pkg::*;
(
	input logic        CLK,
	input logic        RSTb,
	input instr_t      memoryIn,
	input logic        C, Z, S,
	input logic [4:0]  aluOp,
	input logic [15:0] pout,
	input reg_mask_t   LD_reg_ALUb, LD_reg_Mb, LD_reg_Pb, INCb, DECb,
	input reg_idx_t    ALU_A_SEL, ALU_B_SEL, M_SEL, MADDR_SEL,
	input logic        M_ENb, ALU_B_from_inP_b, mem_OEb, mem_WRb
);

	localparam logic [36:0] RST_EXP   = {32'hFFFF_FFFF, 2'b11, 3'd7};
	localparam logic [19:0] FLUSH_EXP = {1'b0, 3'd7, 8'hFF, 8'hFF}; // pc read, nop decode

	int          fail_cnt = 0; // read by the testbench
	logic        fetch_now;    // pc read and stepped this cycle
	instr_t      prev_word;    // memoryIn at the last edge
	instr_t      prev2_word;
	logic        prev_fetch;
	logic        prev2_fetch;
	logic        flag_sel;
	logic        br_taken;
	logic        is_alu, is_br, is_load, load_done, is_store, imm_pair;
	logic [36:0] rst_act;
	logic [18:0] alu_exp, alu_act;
	logic [16:0] imm_exp, imm_act;
	logic [8:0]  br_exp, br_act;
	logic [19:0] flush_act;
	logic [12:0] ld_exp, ld_act;
	logic [8:0]  st_exp, st_act;

	// active low one-hot of register r
	function automatic logic [7:0] one_low(input logic [2:0] r);
		one_low = 8'hFF ^ (8'h01 << r);
	endfunction

	task automatic flag_fail(input string name, input logic [63:0] exp, act);
		fail_cnt = fail_cnt + 1;
		$error("CHECK FAILED %s: expected %0h actual %0h", name, exp, act);
	endtask

	assign fetch_now = !mem_OEb && MADDR_SEL == PC_IDX && !INCb[PC_IDX];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prev_word   <= NOP_WORD;
			prev2_word  <= NOP_WORD;
			prev_fetch  <= 1'b0;
			prev2_fetch <= 1'b0;
		end else begin
			prev_word   <= memoryIn; // decoded in the coming cycle
			prev2_word  <= prev_word;
			prev_fetch  <= fetch_now;
			prev2_fetch <= prev_fetch;
		end
	end

	assign is_alu    = prev_fetch
		&& (prev_word[15:12] == CLS_ALU_RR || prev_word[15:13] == CLS3_ALU_RRR);
	assign is_br     = prev_fetch && prev_word[15:12] == CLS_BRANCH && !prev_word[11];
	assign is_load   = prev_fetch && prev_word[15:12] == CLS_MEM && !prev_word[8];
	assign is_store  = prev_fetch && prev_word[15:12] == CLS_MEM && prev_word[8];
	assign load_done = prev2_fetch && prev2_word[15:12] == CLS_MEM && !prev2_word[8];
	assign imm_pair  = prev2_fetch && prev_fetch && prev2_word[15:12] == CLS_IMM
		&& prev_word[15:12] == CLS_ALU_RI;

	// conditions in pairs, flag then complement; 6 always, 7 never
	assign flag_sel = prev_word[10:9] == 2'd0 ? Z : prev_word[10:9] == 2'd1 ? S : C;
	assign br_taken = prev_word[10:8] == 3'd6
		|| (prev_word[10:8] != 3'd7 && (flag_sel ^ prev_word[8]));

	// top bit set only in the three register form
	assign alu_exp = prev_word[15] ?
		{1'b0, prev_word[12:9], prev_word[5:3], prev_word[2:0], one_low(prev_word[8:6])} :
		{prev_word[3], prev_word[11:8], prev_word[6:4], prev_word[2:0],
		prev_word[7] ? 8'hFF : one_low(prev_word[6:4])};
	assign imm_exp   = {prev2_word[11:0], prev_word[3:0], 1'b0};
	assign br_exp    = br_taken ? {8'h7F, 1'b1} : {8'hFF, 1'b0};
	assign ld_exp    = {one_low(prev2_word[6:4]), prev2_word[2:0], prev2_word[9], prev2_word[10]};
	assign st_exp    = {3'b001, prev_word[6:4], prev_word[2:0]};

	assign rst_act   = {LD_reg_ALUb, LD_reg_Mb, LD_reg_Pb, DECb, M_ENb, mem_WRb, MADDR_SEL};
	assign alu_act   = {aluOp, ALU_A_SEL, ALU_B_SEL, LD_reg_ALUb};
	assign imm_act   = {pout, ALU_B_from_inP_b};
	assign br_act    = {LD_reg_Pb, INCb[PC_IDX]};
	assign flush_act = {mem_OEb, MADDR_SEL, LD_reg_ALUb, LD_reg_Pb};
	assign ld_act    = {LD_reg_Mb, MADDR_SEL, INCb[prev2_word[2:0]], DECb[prev2_word[2:0]]};
	assign st_act    = {M_ENb, mem_WRb, mem_OEb, M_SEL, MADDR_SEL};

	reset_idle: assert property (@(posedge CLK) $rose(RSTb) |-> rst_act == RST_EXP)
		else flag_fail("reset", RST_EXP, $sampled(rst_act));
	alu_fields: assert property (@(posedge CLK) disable iff (!RSTb) is_alu |-> alu_act == alu_exp)
		else flag_fail("alu", $sampled(alu_exp), $sampled(alu_act));
	imm_join: assert property (@(posedge CLK) disable iff (!RSTb) imm_pair |-> imm_act == imm_exp)
		else flag_fail("imm_prefix", $sampled(imm_exp), $sampled(imm_act));
	imm_clear: assert property (@(posedge CLK) disable iff (!RSTb) imm_pair |=> pout[15:4] == 0)
		else flag_fail("imm_prefix", 0, $sampled(pout[15:4]));
	br_decode: assert property (@(posedge CLK) disable iff (!RSTb) is_br |-> br_act == br_exp)
		else flag_fail("branch", $sampled(br_exp), $sampled(br_act));
	br_flush: assert property (@(posedge CLK) disable iff (!RSTb)
		is_br && br_taken |=> flush_act == FLUSH_EXP)
		else flag_fail("branch", FLUSH_EXP, $sampled(flush_act));
	ld_decode: assert property (@(posedge CLK) disable iff (!RSTb) is_load |-> !DECb[PC_IDX])
		else flag_fail("load", 0, $sampled(DECb[PC_IDX]));
	ld_finish: assert property (@(posedge CLK) disable iff (!RSTb) load_done |-> ld_act == ld_exp)
		else flag_fail("load", $sampled(ld_exp), $sampled(ld_act));
	st_decode: assert property (@(posedge CLK) disable iff (!RSTb) is_store |-> st_act == st_exp)
		else flag_fail("store", $sampled(st_exp), $sampled(st_act));

endmodule

bind pipeline16_top pipeline16_props props_inst (.*);

`default_nettype wire

/* test/pipeline16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline16_tb
	import isa_pkg::*;
();

	localparam int MAX_CYCLES = 2000; // about ten times the whole run

	logic        CLK = 1'b0;
	logic        RSTb = 1'b0;
	instr_t      memoryIn = NOP_WORD;
	logic        C = 1'b0;
	logic        Z = 1'b0;
	logic        S = 1'b0;
	logic [4:0]  aluOp;
	logic [15:0] pout;
	reg_mask_t   LD_reg_ALUb, LD_reg_Mb, LD_reg_Pb, INCb, DECb;
	reg_idx_t    ALU_A_SEL, ALU_B_SEL, M_SEL, MADDR_SEL;
	logic        M_ENb, ALU_B_from_inP_b, mem_OEb, mem_WRb;

	int          seed = 32'h5b77;
	int          cycles = 0;
	int          fails_seen = 0; // failing checks up to the last report
	int          tests_run = 0;
	logic [31:0] rnd;

	pipeline16_top pipeline16_top_inst (.*);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	// present a word at the next falling edge on which the DUT fetches
	task automatic fetch_word(input instr_t w);
		@(negedge CLK);
		while (!(MADDR_SEL == PC_IDX && !mem_OEb && !INCb[PC_IDX])) begin
			@(negedge CLK); // stall or flush in progress
		end
		memoryIn = w;
	endtask

	task automatic report_test(input string name);
		int errs;
		repeat (3) fetch_word(NOP_WORD); // drain both stages
		errs = pipeline16_top_inst.props_inst.fail_cnt - fails_seen;
		fails_seen = pipeline16_top_inst.props_inst.fail_cnt;
		tests_run = tests_run + 1;
		$display("test %s finished, %0d failing checks", name, errs);
	endtask

	initial begin
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
		report_test("reset");

		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			fetch_word((i % 2 == 0) ? {CLS_ALU_RR, rnd[11:0]} : {CLS3_ALU_RRR, rnd[12:0]});
		end
		report_test("alu");

		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			fetch_word({CLS_IMM, rnd[27:16]});
			fetch_word({CLS_ALU_RI, rnd[11:0]});
			fetch_word({CLS_ALU_RR, rnd[11:0]}); // decodes without the prefix
		end
		report_test("imm_prefix");

		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			fetch_word({CLS_BRANCH, 1'b0, i[2:0], rnd[7:0]});
			{C, Z, S} = rnd[18:16]; // held through the decode cycle
			@(negedge CLK);
			// dropped when taken, would load its destination otherwise
			memoryIn = {CLS_ALU_RR, rnd[27:24], 1'b0, rnd[22:16]};
		end
		report_test("branch");

		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			// index kept off r7
			fetch_word({CLS_MEM, rnd[11:9], 1'b0, rnd[7:3], (rnd[2:0] == 3'd7) ? 3'd0 : rnd[2:0]});
		end
		report_test("load");

		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			fetch_word({CLS_MEM, rnd[11:9], 1'b1, rnd[7:0]});
		end
		report_test("store");

		$display("tests run %0d, failing checks %0d", tests_run, fails_seen);
		if (fails_seen == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
design/isa_pkg.sv
design/ctl_pkg.sv
design/pipe_if.sv
design/fetch_pipe.sv
design/issue_sequencer.sv
design/stage0_decoder.sv
design/load_completer.sv
design/pipeline16_top.sv
test/pipeline16_props.sv
test/pipeline16_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --no-stop-fail \
	--top-module pipeline16_tb -f compile.f -o pipeline16_sim

./obj_dir/pipeline16_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
